// ==== nes_glue.f ====
common/nes_pkg.sv
design/phase_seq.sv
design/mem_arbiter.sv
design/host_regs.sv
joypad/pad_mapper.sv
joypad/joypad_shift.sv
design/nes_glue.sv
test/nes_glue_checker.sv
test/tb_nes_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the nes_glue testbench under verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_nes_glue \
  -f nes_glue.f -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 &&
grep -qx "test passed" sim.log &&
echo "PASS" ||
{ echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== test/tb_nes_glue.sv ====
// testbench for the console glue top level
// directed tests of host registers, phases, memory commands and joypads
`timescale 1ns/1ps

module tb_nes_glue;

  logic clk = 1'b0;
  logic sys_resetn, psel, penable, pwrite, pready, pslverr;
  logic loader_done, loader_fail, loader_write, loader_refresh, loader_reset;
  logic rom_byte_valid, nes_reset, nes_run, mem_read_cpu, mem_read_ppu, mem_write;
  logic joypad_strobe;
  logic [1:0] joypad_clock, joypad_data;
  logic [7:0] paddr, pwdata, prdata, loader_data, rom_byte, mem_dout, cpu_din, ppu_din;
  logic [7:0] ram_din, ram_dout_a, ram_dout_b, ds_rx1_0, ds_rx1_1, ds_rx2_0, ds_rx2_1;
  logic [nes_pkg::ADDR_W-1:0] loader_addr, mem_addr, ram_addr;
  nes_pkg::mem_cmd_t ram_cmd;
  int seed = 32'hd87b;
  int checks = 0, errors = 0, mark_c = 0, mark_e = 0;

  nes_glue i_dut (.*);

  always #20 clk = ~clk;

  // sdram model, read data is the address low byte xor a5
  always begin
    @(posedge clk);
    #5;
    if (ram_cmd == nes_pkg::CMD_READ_CPU || ram_cmd == nes_pkg::CMD_READ_PPU) begin
      ram_dout_a = ram_addr[7:0] ^ 8'ha5;
      ram_dout_b = ram_addr[7:0] ^ 8'ha5;
    end
  end

  task automatic step();
    @(posedge clk);
    #5;   // inputs change just after the edge
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, exp);
    errors++;
    $display("FAIL %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic check_cmd(input string name, input nes_pkg::mem_cmd_t got, exp);
    checks++;
    if (got !== exp) mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, exp);
    checks++;
    if (got !== exp) mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_addr(input string name, input logic [nes_pkg::ADDR_W-1:0] got, exp);
    checks++;
    if (got !== exp) mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_btn(input string name, input nes_pkg::btn_t got, exp);
    checks++;
    if (got !== exp) mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    checks++;
    if (got !== exp) mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - mark_c, errors - mark_e);
    mark_c = checks;
    mark_e = errors;
  endtask

  // waits for the next run strobe or memory slot
  task automatic wait_strobe(input logic want_run);
    int n;
    logic hit;
    n = 0;
    hit = 1'b0;
    while (!hit && n < 20) begin
      step();
      hit = want_run ? nes_run : i_dut.mem_slot;
      n++;
    end
    if (!hit) begin
      $display("timeout, no %s strobe seen", want_run ? "nes_run" : "mem_slot");
      $display("test failed");
      $finish;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, data);
    paddr = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel = 1'b1;
    penable = 1'b0;
    step();
    penable = 1'b1;
    step();
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [7:0] data, output logic err);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    step();
    penable = 1'b1;
    #1;
    data = prdata;
    err = pslverr;
    check_bit("pready", pready, 1'b1);   // no wait states
    step();
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // loader model, one write strobe
  task automatic loader_store(input logic [nes_pkg::ADDR_W-1:0] addr, input logic [7:0] data);
    loader_addr = addr;
    loader_data = data;
    loader_write = 1'b1;
    step();
    loader_write = 1'b0;
  endtask

  task automatic strobe_pads();
    joypad_strobe = 1'b1;
    step();
    joypad_strobe = 1'b0;
    step();
  endtask

  task automatic shift_out(input int port, output nes_pkg::btn_t val);
    logic [7:0] bits;
    for (int i = 0; i < 8; i++) begin
      bits[i] = joypad_data[port];   // lsb comes out first
      joypad_clock[port] = 1'b1;
      step();
      joypad_clock[port] = 1'b0;
      step();
    end
    val = bits;
  endtask

  task automatic test_registers();
    logic [7:0] b1, b2, cf, rd;
    logic err;
    b1 = 8'($random(seed));
    b2 = 8'($random(seed));
    cf = 8'($random(seed)) & 8'hfe;
    apb_write(nes_pkg::REG_BTN1, b1);
    apb_write(nes_pkg::REG_BTN2, b2);
    apb_write(nes_pkg::REG_CONF, cf);
    check_bit("loader_reset", loader_reset, 1'b0);
    apb_read(nes_pkg::REG_BTN1, rd, err);
    check_byte("prdata", rd, b1);
    apb_read(nes_pkg::REG_BTN2, rd, err);
    check_byte("prdata", rd, b2);
    apb_read(nes_pkg::REG_CONF, rd, err);
    check_byte("prdata", rd, cf);
    check_bit("pslverr", err, 1'b0);
    loader_fail = 1'b1;
    apb_read(nes_pkg::REG_STATUS, rd, err);
    check_byte("status", rd, 8'h02);
    loader_fail = 1'b0;
    loader_done = 1'b1;
    apb_read(nes_pkg::REG_STATUS, rd, err);
    check_byte("status", rd, 8'h01);
    loader_done = 1'b0;
    apb_read(8'h36, rd, err);   // hole in the map
    check_bit("pslverr", err, 1'b1);
    apb_write(nes_pkg::REG_CONF, 8'h01);
    check_bit("loader_reset", loader_reset, 1'b1);
    apb_write(nes_pkg::REG_CONF, 8'h00);
    apb_write(nes_pkg::REG_ROM_DATA, b2);
    check_bit("rom_byte_valid", rom_byte_valid, 1'b1);
    check_byte("rom_byte", rom_byte, b2);
    step();
    check_bit("rom_byte_valid", rom_byte_valid, 1'b0);
    end_test("registers");
  endtask

  task automatic test_phases();
    repeat (3) step();
    for (int i = 0; i < 10; i++) begin
      check_bit("nes_reset", nes_reset, 1'b1);
      check_bit("nes_run", nes_run, 1'b0);
      check_bit("mem_slot", i_dut.mem_slot, 1'b0);
      step();
    end
    loader_done = 1'b1;
    wait_strobe(1'b0);
    for (int i = 0; i < 3 * nes_pkg::NUM_PHASES; i++) begin
      check_bit("nes_reset", nes_reset, 1'b0);
      check_bit("mem_slot", i_dut.mem_slot, i % nes_pkg::NUM_PHASES == 0);
      check_bit("nes_run", nes_run, i % nes_pkg::NUM_PHASES == 4);
      step();
    end
    end_test("phases");
  endtask

  task automatic test_loader_write();
    logic [nes_pkg::ADDR_W-1:0] a;
    logic [7:0] d;
    a = nes_pkg::ADDR_W'($random(seed));
    d = 8'($random(seed));
    wait_strobe(1'b0);
    step();
    check_bit("mem_slot", i_dut.mem_slot, 1'b0);
    loader_store(a, d);
    check_cmd("ram_cmd", ram_cmd, nes_pkg::CMD_WRITE);
    check_addr("ram_addr", ram_addr, a);
    check_byte("ram_din", ram_din, d);
    step();
    check_cmd("ram_cmd", ram_cmd, nes_pkg::CMD_NONE);
    end_test("loader_write");
  endtask

  task automatic test_console_access();
    logic [nes_pkg::ADDR_W-1:0] a;
    logic [nes_pkg::ADDR_W-1:0] a2;
    a = nes_pkg::ADDR_W'($random(seed));
    a2 = nes_pkg::ADDR_W'($random(seed));
    a2[7:0] = ~a[7:0];   // ppu data differs from cpu data
    mem_addr = a;
    mem_read_cpu = 1'b1;
    wait_strobe(1'b0);
    step();
    mem_read_cpu = 1'b0;
    check_cmd("ram_cmd", ram_cmd, nes_pkg::CMD_READ_CPU);
    check_addr("ram_addr", ram_addr, a);
    wait_strobe(1'b1);   // read data captured here
    wait_strobe(1'b0);
    step();
    check_cmd("ram_cmd", ram_cmd, nes_pkg::CMD_REFRESH);
    wait_strobe(1'b1);
    check_byte("cpu_din", cpu_din, a[7:0] ^ 8'ha5);
    mem_addr = a2;
    mem_read_ppu = 1'b1;
    wait_strobe(1'b0);
    step();
    mem_read_ppu = 1'b0;
    check_cmd("ram_cmd", ram_cmd, nes_pkg::CMD_READ_PPU);
    check_addr("ram_addr", ram_addr, a2);
    wait_strobe(1'b1);
    step();   // capture edge has passed
    check_byte("ppu_din", ppu_din, a2[7:0] ^ 8'ha5);
    check_byte("cpu_din", cpu_din, a[7:0] ^ 8'ha5);
    end_test("console_access");
  endtask

  task automatic test_joypad();
    nes_pkg::btn_t got;
    apb_write(nes_pkg::REG_BTN1, 8'h00);
    apb_write(nes_pkg::REG_BTN2, 8'h00);
    ds_rx1_0 = 8'h77;   // left, start
    ds_rx1_1 = 8'hdf;   // cross
    ds_rx2_0 = 8'hbe;   // down, select
    ds_rx2_1 = 8'hbf;   // circle
    strobe_pads();
    shift_out(0, got);
    check_btn("joypad_data[0]", got, 8'h49);
    shift_out(1, got);
    check_btn("joypad_data[1]", got, 8'h26);
    apb_write(nes_pkg::REG_BTN1, 8'h80);   // host presses right
    strobe_pads();
    shift_out(0, got);
    check_btn("joypad_data[0]", got, 8'hc9);
    end_test("joypad");
  endtask

  task automatic test_autofire();
    logic seen_set, seen_clr;
    seen_set = 1'b0;
    seen_clr = 1'b0;
    apb_write(nes_pkg::REG_BTN1, 8'h00);
    ds_rx1_0 = 8'hff;
    ds_rx1_1 = 8'h7f;   // square held
    for (int i = 0; i < 16; i++) begin
      joypad_strobe = 1'b1;
      step();
      joypad_strobe = 1'b0;
      joypad_clock[0] = 1'b1;
      step();
      joypad_clock[0] = 1'b0;
      step();
      if (joypad_data[0]) seen_set = 1'b1;   // B after one shift
      else seen_clr = 1'b1;
      repeat (nes_pkg::AUTOFIRE_HALF + 1 - 3) step();
    end
    check_bit("autofire B set", seen_set, 1'b1);
    check_bit("autofire B clear", seen_clr, 1'b1);
    ds_rx1_1 = 8'hff;
    end_test("autofire");
  endtask

  initial begin
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {loader_done, loader_fail, loader_write, loader_refresh, loader_addr, loader_data} = '0;
    {mem_read_cpu, mem_read_ppu, mem_write, mem_addr, mem_dout} = '0;
    {joypad_strobe, joypad_clock, ram_dout_a, ram_dout_b} = '0;
    {ds_rx1_0, ds_rx1_1, ds_rx2_0, ds_rx2_1} = '1;   // all buttons released
    sys_resetn = 1'b0;
    repeat (4) step();
    check_bit("loader_reset", loader_reset, 1'b1);
    check_bit("rom_byte_valid", rom_byte_valid, 1'b0);
    check_cmd("ram_cmd", ram_cmd, nes_pkg::CMD_NONE);
    sys_resetn = 1'b1;
    step();
    test_registers();
    test_phases();
    test_loader_write();
    test_console_access();
    test_joypad();
    test_autofire();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== test/nes_glue_checker.sv ====
// console glue assertions
// apb ready, single-cycle run strobe and idle memory command
`timescale 1ns/1ps

module nes_glue_checker (
  input logic              clk,
  input logic              sys_resetn,
  input logic              pready,
  input logic              nes_run,
  input logic              mem_slot,
  input logic              loader_write,
  input logic              loader_refresh,
  input nes_pkg::mem_cmd_t ram_cmd
);

  a_pready: assert property (@(posedge clk) disable iff (!sys_resetn) pready)
    else $error("pready low");

  // run strobe is one clock wide
  a_run_single: assert property (@(posedge clk) disable iff (!sys_resetn)
    nes_run |=> !nes_run)
    else $error("nes_run high in two consecutive cycles");

  // no request source, no command
  a_cmd_idle: assert property (@(posedge clk) disable iff (!sys_resetn)
    (!loader_write && !loader_refresh && !mem_slot) |=> ram_cmd == nes_pkg::CMD_NONE)
    else $error("ram_cmd issued without a request");

endmodule

bind nes_glue nes_glue_checker i_checker (
  .clk(clk), .sys_resetn(sys_resetn), .pready(pready), .nes_run(nes_run),
  .mem_slot(mem_slot), .loader_write(loader_write), .loader_refresh(loader_refresh),
  .ram_cmd(ram_cmd)
);

// ==== design/nes_glue.sv ====
// console glue top level
// connects the phase sequencer, memory arbiter, host registers,
// the two pad mappers and the joypad shift registers
`timescale 1ns/1ps

module nes_glue (
  input  logic                           clk,
  input  logic                           sys_resetn,
  // apb host
  input  logic [nes_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [nes_pkg::DATA_W-1:0]     pwdata,
  output logic [nes_pkg::DATA_W-1:0]     prdata,
  output logic                           pready,
  output logic                           pslverr,
  // game loader
  input  logic                           loader_done,
  input  logic                           loader_fail,
  input  logic [nes_pkg::ADDR_W-1:0]     loader_addr,
  input  logic [nes_pkg::DATA_W-1:0]     loader_data,
  input  logic                           loader_write,
  input  logic                           loader_refresh,
  output logic                           loader_reset,
  output logic [nes_pkg::DATA_W-1:0]     rom_byte,
  output logic                           rom_byte_valid,
  // console core
  output logic                           nes_reset,
  output logic                           nes_run,
  input  logic                           mem_read_cpu,
  input  logic                           mem_read_ppu,
  input  logic                           mem_write,
  input  logic [nes_pkg::ADDR_W-1:0]     mem_addr,
  input  logic [nes_pkg::DATA_W-1:0]     mem_dout,
  output logic [nes_pkg::DATA_W-1:0]     cpu_din,
  output logic [nes_pkg::DATA_W-1:0]     ppu_din,
  input  logic                           joypad_strobe,
  input  logic [1:0]                     joypad_clock,
  output logic [1:0]                     joypad_data,
  // sdram controller
  output nes_pkg::mem_cmd_t              ram_cmd,
  output logic [nes_pkg::ADDR_W-1:0]     ram_addr,
  output logic [nes_pkg::DATA_W-1:0]     ram_din,
  input  logic [nes_pkg::DATA_W-1:0]     ram_dout_a,
  input  logic [nes_pkg::DATA_W-1:0]     ram_dout_b,
  // dualshock receive bytes, two per pad
  input  logic [nes_pkg::DATA_W-1:0]     ds_rx1_0,
  input  logic [nes_pkg::DATA_W-1:0]     ds_rx1_1,
  input  logic [nes_pkg::DATA_W-1:0]     ds_rx2_0,
  input  logic [nes_pkg::DATA_W-1:0]     ds_rx2_1
);

  logic          mem_slot;
  logic          capture;
  nes_pkg::btn_t host_btn1, host_btn2;
  nes_pkg::btn_t pad1_btn, pad2_btn;

  phase_seq u_phase_seq (
    .clk(clk), .sys_resetn(sys_resetn), .loader_done(loader_done),
    .nes_reset(nes_reset), .mem_slot(mem_slot), .nes_run(nes_run), .capture(capture)
  );

  mem_arbiter u_mem_arbiter (
    .clk(clk), .sys_resetn(sys_resetn), .mem_slot(mem_slot), .capture(capture),
    .mem_read_cpu(mem_read_cpu), .mem_read_ppu(mem_read_ppu), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_dout(mem_dout),
    .loader_addr(loader_addr), .loader_data(loader_data),
    .loader_write(loader_write), .loader_refresh(loader_refresh),
    .ram_dout_a(ram_dout_a), .ram_dout_b(ram_dout_b),
    .ram_cmd(ram_cmd), .ram_addr(ram_addr), .ram_din(ram_din),
    .cpu_din(cpu_din), .ppu_din(ppu_din)
  );

  host_regs u_host_regs (
    .clk(clk), .sys_resetn(sys_resetn),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .loader_done(loader_done), .loader_fail(loader_fail),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .loader_reset(loader_reset), .rom_byte(rom_byte), .rom_byte_valid(rom_byte_valid),
    .host_btn1(host_btn1), .host_btn2(host_btn2)
  );

  pad_mapper u_pad1 (
    .clk(clk), .sys_resetn(sys_resetn), .ds_rx0(ds_rx1_0), .ds_rx1(ds_rx1_1),
    .pad_btn(pad1_btn)
  );

  pad_mapper u_pad2 (
    .clk(clk), .sys_resetn(sys_resetn), .ds_rx0(ds_rx2_0), .ds_rx1(ds_rx2_1),
    .pad_btn(pad2_btn)
  );

  joypad_shift u_joypad_shift (
    .clk(clk), .sys_resetn(sys_resetn),
    .joypad_strobe(joypad_strobe), .joypad_clock(joypad_clock),
    .btn1_in(pad1_btn), .btn2_in(pad2_btn),
    .host_btn1(host_btn1), .host_btn2(host_btn2),
    .joypad_data(joypad_data)
  );

endmodule

// ==== joypad/joypad_shift.sv ====
// console joypad shift registers for both ports
// strobe loads the host override ORed with the mapped buttons, each port
// then shifts out lsb first on the falling edge of its own clock line
`timescale 1ns/1ps

module joypad_shift (
  input  logic          clk,
  input  logic          sys_resetn,
  input  logic          joypad_strobe,
  input  logic [1:0]    joypad_clock,
  input  nes_pkg::btn_t btn1_in,
  input  nes_pkg::btn_t btn2_in,
  input  nes_pkg::btn_t host_btn1,
  input  nes_pkg::btn_t host_btn2,
  output logic [1:0]    joypad_data
);

  logic [1:0][nes_pkg::DATA_W-1:0] load_val;
  logic [1:0][nes_pkg::DATA_W-1:0] bits;
  logic [1:0]                      clk_q;   // registered joypad clocks
  logic [1:0]                      fall;

  assign load_val[0] = btn1_in | host_btn1;
  assign load_val[1] = btn2_in | host_btn2;

  assign fall = clk_q & ~joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      clk_q <= '0;
      bits  <= '0;
    end else begin
      clk_q <= joypad_clock;
      for (int i = 0; i < 2; i++) begin
        if (joypad_strobe) begin
          bits[i] <= load_val[i];
        end else if (fall[i]) begin
          bits[i] <= {1'b0, bits[i][nes_pkg::DATA_W-1:1]};   // zero fill
        end
      end
    end
  end

  assign joypad_data = {bits[1][0], bits[0][0]};

endmodule

// ==== joypad/pad_mapper.sv ====
// dualshock to console button mapping for one pad
// active-low receive bits are inverted and reordered; square and triangle
// add autofire on B and A
`timescale 1ns/1ps

module pad_mapper (
  input  logic                       clk,
  input  logic                       sys_resetn,
  input  logic [nes_pkg::DATA_W-1:0] ds_rx0,   // L D R U St R3 L3 Se
  input  logic [nes_pkg::DATA_W-1:0] ds_rx1,   // sq O X tri R1 L1 R2 L2
  output nes_pkg::btn_t              pad_btn
);

  logic [1:0] af_held;   // [1] square, [0] triangle
  logic [1:0] af_wave;

  assign af_held = {~ds_rx1[7], ~ds_rx1[4]};

  // one square wave per autofire button
  for (genvar i = 0; i < 2; i++) begin : g_af
    logic [$clog2(2 * nes_pkg::AUTOFIRE_HALF)-1:0] cnt;

    always_ff @(posedge clk) begin
      if (!sys_resetn || !af_held[i]) begin
        cnt <= '0;   // restart on every press
      end else if (cnt == 2 * nes_pkg::AUTOFIRE_HALF - 1) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end

    // high for the first half period, so a press fires at once
    assign af_wave[i] = af_held[i] && (cnt < nes_pkg::AUTOFIRE_HALF);
  end

  always_comb begin
    pad_btn.right  = ~ds_rx0[5];
    pad_btn.left   = ~ds_rx0[7];
    pad_btn.down   = ~ds_rx0[6];
    pad_btn.up     = ~ds_rx0[4];
    pad_btn.start  = ~ds_rx0[3];
    pad_btn.select = ~ds_rx0[0];
    pad_btn.b      = ~ds_rx1[6] | af_wave[1];   // circle, square autofire
    pad_btn.a      = ~ds_rx1[5] | af_wave[0];   // cross, triangle autofire
  end

endmodule

// ==== design/host_regs.sv ====
// host register block
// apb slave holding loader config, button overrides, rom data port and status
// rom data writes become single-cycle byte strobes for the game loader
`timescale 1ns/1ps

module host_regs (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  logic [nes_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [nes_pkg::DATA_W-1:0]     pwdata,
  input  logic                           loader_done,
  input  logic                           loader_fail,
  output logic [nes_pkg::DATA_W-1:0]     prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           loader_reset,
  output logic [nes_pkg::DATA_W-1:0]     rom_byte,
  output logic                           rom_byte_valid,
  output nes_pkg::btn_t                  host_btn1,
  output nes_pkg::btn_t                  host_btn2
);

  logic                       access;
  logic                       wr;
  logic                       mapped;
  logic [nes_pkg::DATA_W-1:0] conf;   // bit 0 holds the loader in reset

  assign access = psel && penable;
  assign wr     = access && pwrite;

  assign mapped = (paddr == nes_pkg::REG_CONF)  || (paddr == nes_pkg::REG_ROM_DATA) ||
                  (paddr == nes_pkg::REG_BTN1)  || (paddr == nes_pkg::REG_BTN2) ||
                  (paddr == nes_pkg::REG_STATUS);

  assign pready  = 1'b1;               // no wait states
  assign pslverr = access && !mapped;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf           <= '0;
      host_btn1      <= '0;
      host_btn2      <= '0;
      rom_byte_valid <= 1'b0;
    end else begin
      if (wr && paddr == nes_pkg::REG_CONF) conf      <= pwdata;
      if (wr && paddr == nes_pkg::REG_BTN1) host_btn1 <= pwdata;
      if (wr && paddr == nes_pkg::REG_BTN2) host_btn2 <= pwdata;
      rom_byte_valid <= wr && (paddr == nes_pkg::REG_ROM_DATA);
    end
  end

  // data byte for the loader, qualified by rom_byte_valid
  always_ff @(posedge clk) begin
    if (wr && paddr == nes_pkg::REG_ROM_DATA) rom_byte <= pwdata;
  end

  assign loader_reset = !sys_resetn || conf[0];

  // read mux, valid in the access phase
  always_comb begin
    case (paddr)
      nes_pkg::REG_CONF:     prdata = conf;
      nes_pkg::REG_ROM_DATA: prdata = rom_byte;   // last byte sent
      nes_pkg::REG_BTN1:     prdata = host_btn1;
      nes_pkg::REG_BTN2:     prdata = host_btn2;
      nes_pkg::REG_STATUS:   prdata = {6'b0, loader_fail, loader_done};
      default:               prdata = '0;
    endcase
  end

endmodule

// ==== design/mem_arbiter.sv ====
// memory arbiter
// merges loader writes, console reads/writes and refresh into one registered
// command stream for the sdram controller, and steers read data back
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                         clk,
  input  logic                         sys_resetn,
  input  logic                         mem_slot,
  input  logic                         capture,
  input  logic                         mem_read_cpu,
  input  logic                         mem_read_ppu,
  input  logic                         mem_write,
  input  logic [nes_pkg::ADDR_W-1:0]   mem_addr,
  input  logic [nes_pkg::DATA_W-1:0]   mem_dout,
  input  logic [nes_pkg::ADDR_W-1:0]   loader_addr,
  input  logic [nes_pkg::DATA_W-1:0]   loader_data,
  input  logic                         loader_write,
  input  logic                         loader_refresh,
  input  logic [nes_pkg::DATA_W-1:0]   ram_dout_a,
  input  logic [nes_pkg::DATA_W-1:0]   ram_dout_b,
  output nes_pkg::mem_cmd_t            ram_cmd,
  output logic [nes_pkg::ADDR_W-1:0]   ram_addr,
  output logic [nes_pkg::DATA_W-1:0]   ram_din,
  output logic [nes_pkg::DATA_W-1:0]   cpu_din,
  output logic [nes_pkg::DATA_W-1:0]   ppu_din
);

  nes_pkg::mem_cmd_t            sel_cmd;
  logic [nes_pkg::ADDR_W-1:0]   sel_addr;
  logic [nes_pkg::DATA_W-1:0]   sel_din;
  nes_pkg::mem_cmd_t            last_cmd;   // console cmd whose data is due

  // loader wins at any phase, console only in its slot
  always_comb begin
    sel_cmd  = nes_pkg::CMD_NONE;
    sel_addr = mem_addr;
    sel_din  = mem_dout;
    if (loader_write) begin
      sel_cmd  = nes_pkg::CMD_WRITE;
      sel_addr = loader_addr;
      sel_din  = loader_data;
    end else if (mem_slot) begin
      if (mem_read_cpu)      sel_cmd = nes_pkg::CMD_READ_CPU;
      else if (mem_read_ppu) sel_cmd = nes_pkg::CMD_READ_PPU;
      else if (mem_write)    sel_cmd = nes_pkg::CMD_WRITE;
      else                   sel_cmd = nes_pkg::CMD_REFRESH;  // idle slot
    end else if (loader_refresh) begin
      sel_cmd = nes_pkg::CMD_REFRESH;
    end
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      ram_cmd  <= nes_pkg::CMD_NONE;
      last_cmd <= nes_pkg::CMD_NONE;
    end else begin
      ram_cmd <= sel_cmd;   // one-cycle command
      if (mem_slot && !loader_write) last_cmd <= sel_cmd;
    end
  end

  always_ff @(posedge clk) begin
    ram_addr <= sel_addr;
    ram_din  <= sel_din;
  end

  // read data holds until the next capture
  always_ff @(posedge clk) begin
    if (capture && last_cmd == nes_pkg::CMD_READ_CPU) cpu_din <= ram_dout_a;
    if (capture && last_cmd == nes_pkg::CMD_READ_PPU) ppu_din <= ram_dout_b;
  end

endmodule

// ==== design/phase_seq.sv ====
// five-phase clock-enable sequencer
// holds the console in reset until the game is loaded, then gives one
// memory slot and one console run strobe per five clocks
`timescale 1ns/1ps

module phase_seq (
  input  logic clk,
  input  logic sys_resetn,
  input  logic loader_done,
  output logic nes_reset,
  output logic mem_slot,
  output logic nes_run,
  output logic capture
);

  nes_pkg::phase_t phase;
  logic            last_phase;

  assign last_phase = (phase == nes_pkg::phase_t'(nes_pkg::NUM_PHASES - 1));

  // console stays in reset until loading completes
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      nes_reset <= 1'b1;
    end else begin
      nes_reset <= !loader_done;
    end
  end

  // counter parked on the memory phase during console reset
  always_ff @(posedge clk) begin
    if (!sys_resetn || nes_reset) begin
      phase <= nes_pkg::PH_MEM;
    end else if (last_phase) begin
      phase <= nes_pkg::PH_MEM;
    end else begin
      phase <= nes_pkg::phase_t'(phase + 3'd1);
    end
  end

  assign mem_slot = !nes_reset && (phase == nes_pkg::PH_MEM);
  assign nes_run  = !nes_reset && (phase == nes_pkg::PH_NES);

  // read data lands READ_DELAY after the cmd goes out on phase 1
  assign capture  = !nes_reset &&
                    (phase == nes_pkg::phase_t'(1 + nes_pkg::READ_DELAY));

endmodule

// ==== common/nes_pkg.sv ====
// console glue shared definitions
// widths, host register map, phase timing and the enums used across the blocks
package nes_pkg;

  localparam int ADDR_W     = 22;   // 4 MB memory space
  localparam int DATA_W     = 8;
  localparam int APB_ADDR_W = 8;

  // console cycle timing
  localparam int NUM_PHASES    = 5;
  localparam int READ_DELAY    = 3;  // registered read cmd to valid controller data
  localparam int AUTOFIRE_HALF = 8;  // clocks per half period, short for sim

  // host register map
  localparam logic [APB_ADDR_W-1:0] REG_CONF     = 8'h35;
  localparam logic [APB_ADDR_W-1:0] REG_ROM_DATA = 8'h37;
  localparam logic [APB_ADDR_W-1:0] REG_BTN1     = 8'h40;
  localparam logic [APB_ADDR_W-1:0] REG_BTN2     = 8'h41;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 8'h42;

  // sequencer phases, memory slot first and console last
  typedef enum logic [2:0] {
    PH_MEM,
    PH_ACT,
    PH_RW,
    PH_WAIT,
    PH_NES
  } phase_t;

  // command to the sdram controller
  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_READ_CPU,
    CMD_READ_PPU,
    CMD_WRITE,
    CMD_REFRESH
  } mem_cmd_t;

  // console button byte, msb first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } btn_t;

endpackage
